// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pvr_regs_tb
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
logic/pvr_bus_pkg.sv
logic/pvr_map_pkg.sv
logic/pvr_palette_ram.sv
logic/pvr_reg_file.sv
logic/pvr_bus_fsm.sv
logic/pvr_regs.sv
testbench/pvr_regs_tb.sv

// File: logic/pvr_bus_fsm.sv
`timescale 1ns/1ps

module pvr_bus_fsm
	import pvr_bus_pkg::*, pvr_map_pkg::*;
(
	input  logic       clock,
	input  logic       reset_n,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  bus_addr_t  wb_adr,
	input  bus_word_t  reg_rdata,  // combinational from reg file
	input  bus_word_t  pal_rdata,  // one cycle after pal_rd
	output logic       wb_ack,
	output bus_word_t  wb_dat_r,
	output logic       reg_wr,
	output logic       pal_wr,
	output logic       pal_rd,
	output pal_index_t pal_index
);

	bus_state_t state;
	logic       req;     // new cycle seen while idle
	logic       pal_hit; // address in palette window

	assign req       = wb_cyc && wb_stb && (state == st_idle);
	assign pal_hit   = (wb_adr & PAL_MASK) == PAL_BASE;
	assign pal_index = wb_adr[PAL_IDX_W+1:2]; // word index, bits 11..2

	// strobes fire in the accept cycle so the write lands on the accept edge
	assign reg_wr = req && wb_we && !pal_hit;
	assign pal_wr = req && wb_we && pal_hit;
	assign pal_rd = req && !wb_we && pal_hit;
	assign wb_ack = (state == st_ack);

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (pal_rd)
						state <= st_pal_wait; // extra cycle for ram output
					else if (req)
						state <= st_ack;
				end
				st_pal_wait: state <= st_ack;
				st_ack:      state <= st_idle; // master drops stb after ack
				default:     state <= st_idle;
			endcase
		end
	end

	// read data only changes on reads, writes leave it alone
	always_ff @(posedge clock) begin
		if (req && !wb_we && !pal_hit)
			wb_dat_r <= reg_rdata; // register or zero for unmapped
		else if (state == st_pal_wait)
			wb_dat_r <= pal_rdata;
	end

	// ack only answers a live request
	ack_in_cycle: assert property (@(posedge clock) disable iff (!reset_n)
		wb_ack |-> (wb_cyc && wb_stb));

	// single cycle ack per transfer
	ack_one_cycle: assert property (@(posedge clock) disable iff (!reset_n)
		wb_ack |=> !wb_ack);

	// reg file and palette never strobed together
	one_strobe: assert property (@(posedge clock) disable iff (!reset_n)
		$onehot0({reg_wr, pal_wr, pal_rd}));

endmodule

// File: logic/pvr_bus_pkg.sv
package pvr_bus_pkg;

	localparam int ADDR_W    = 16;   // byte address width
	localparam int DATA_W    = 32;   // bus and register word
	localparam int PAL_IDX_W = 10;   // palette word index
	localparam int PAL_DEPTH = 1024; // palette words

	typedef logic [ADDR_W-1:0]    bus_addr_t;
	typedef logic [DATA_W-1:0]    bus_word_t;
	typedef logic [PAL_IDX_W-1:0] pal_index_t;

	// slave side of the wishbone classic cycle
	typedef enum logic [1:0] {
		st_idle     = 2'd0, // waiting for cyc and stb
		st_pal_wait = 2'd1, // palette read data on its way
		st_ack      = 2'd2  // ack for one cycle
	} bus_state_t;

endpackage

// File: logic/pvr_map_pkg.sv
package pvr_map_pkg;

	// identity words, read only
	localparam logic [31:0] DEVICE_ID       = 32'h17FD11DB;
	localparam logic [31:0] DEVICE_REVISION = 32'h00000011;

	// byte offsets inside the register space
	localparam logic [15:0] id_off              = 16'h0000; // device id
	localparam logic [15:0] revision_off        = 16'h0004; // revision number
	localparam logic [15:0] softreset_off       = 16'h0008; // core and TA soft reset
	localparam logic [15:0] startrender_off     = 16'h0014; // drawing start
	localparam logic [15:0] param_base_off      = 16'h0020; // isp parameter base, external
	localparam logic [15:0] region_base_off     = 16'h002C; // region array base, external
	localparam logic [15:0] span_sort_cfg_off   = 16'h0030; // span sorter control
	localparam logic [15:0] vo_border_col_off   = 16'h0040; // border colour
	localparam logic [15:0] fb_r_ctrl_off       = 16'h0044; // fb read control
	localparam logic [15:0] fb_w_ctrl_off       = 16'h0048; // fb write control
	localparam logic [15:0] fb_w_linestride_off = 16'h004C; // fb line stride
	localparam logic [15:0] fb_r_sof1_off       = 16'h0050; // read start field 1, external
	localparam logic [15:0] fb_r_sof2_off       = 16'h0054; // read start field 2, external
	localparam logic [15:0] fb_r_size_off       = 16'h005C; // fb xy size
	localparam logic [15:0] fb_w_sof1_off       = 16'h0060; // write start field 1
	localparam logic [15:0] fb_w_sof2_off       = 16'h0064; // write start field 2
	localparam logic [15:0] fb_x_clip_off       = 16'h0068; // x clip
	localparam logic [15:0] fb_y_clip_off       = 16'h006C; // y clip
	localparam logic [15:0] fpu_param_cfg_off   = 16'h007C; // parameter read cfg, external
	localparam logic [15:0] isp_backgnd_d_off   = 16'h0088; // background depth
	localparam logic [15:0] isp_backgnd_t_off   = 16'h008C; // background tag
	localparam logic [15:0] spg_control_off     = 16'h00D0; // sync pulse gen control
	localparam logic [15:0] text_control_off    = 16'h00E4; // texturing control, external
	localparam logic [15:0] vo_control_off      = 16'h00E8; // video out control
	localparam logic [15:0] pal_ram_ctrl_off    = 16'h0108; // palette format, external
	localparam logic [15:0] ta_alloc_ctrl_off   = 16'h0140; // object list control, external

	// palette window 0x1000..0x1FFC, picked out by the top nibble
	localparam logic [15:0] PAL_BASE = 16'h1000;
	localparam logic [15:0] PAL_MASK = 16'hF000;

endpackage

// File: logic/pvr_palette_ram.sv
`timescale 1ns/1ps

module pvr_palette_ram
	import pvr_bus_pkg::*;
(
	input  logic       clock,
	input  logic       pal_wr,    // write strobe from bus fsm
	input  logic       pal_rd,    // read strobe from bus fsm
	input  pal_index_t pal_index,
	input  bus_word_t  wb_dat_w,
	output bus_word_t  pal_rdata  // valid the cycle after pal_rd
);

	bus_word_t mem [PAL_DEPTH]; // contents undefined until written

	always_ff @(posedge clock) begin
		if (pal_wr)
			mem[pal_index] <= wb_dat_w;
	end

	// output register holds between reads
	always_ff @(posedge clock) begin
		if (pal_rd)
			pal_rdata <= mem[pal_index];
	end

	// single port, one access per cycle
	no_rd_wr: assert property (@(posedge clock)
		!(pal_wr && pal_rd));

endmodule

// File: logic/pvr_reg_file.sv
`timescale 1ns/1ps

module pvr_reg_file
	import pvr_bus_pkg::*, pvr_map_pkg::*;
(
	input  logic      clock,
	input  logic      reset_n,
	input  logic      reg_wr,          // one cycle write strobe
	input  bus_addr_t wb_adr,
	input  bus_word_t wb_dat_w,
	input  bus_word_t param_base,      // words owned outside this block
	input  bus_word_t region_base,
	input  bus_word_t fb_r_sof1,
	input  bus_word_t fb_r_sof2,
	input  bus_word_t fpu_param_cfg,
	input  bus_word_t text_control,
	input  bus_word_t pal_ram_ctrl,
	input  bus_word_t ta_alloc_ctrl,
	output bus_word_t reg_rdata,       // combinational read mux
	output bus_word_t softreset,
	output bus_word_t startrender,
	output bus_word_t span_sort_cfg,
	output bus_word_t vo_border_col,
	output bus_word_t fb_r_ctrl,
	output bus_word_t fb_w_ctrl,
	output bus_word_t fb_w_linestride,
	output bus_word_t fb_r_size,
	output bus_word_t fb_w_sof1,
	output bus_word_t fb_w_sof2,
	output bus_word_t fb_x_clip,
	output bus_word_t fb_y_clip,
	output bus_word_t isp_backgnd_d,
	output bus_word_t isp_backgnd_t,
	output bus_word_t spg_control,
	output bus_word_t vo_control
);

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			softreset       <= '0;
			startrender     <= '0;
			span_sort_cfg   <= '0;
			vo_border_col   <= '0;
			fb_r_ctrl       <= '0;
			fb_w_ctrl       <= '0;
			fb_w_linestride <= '0;
			fb_r_size       <= '0;
			fb_w_sof1       <= '0;
			fb_w_sof2       <= '0;
			fb_x_clip       <= '0;
			fb_y_clip       <= '0;
			isp_backgnd_d   <= '0;
			isp_backgnd_t   <= '0;
			spg_control     <= '0;
			vo_control      <= '0;
		end else if (reg_wr) begin
			case (wb_adr) // id, external and unknown offsets fall to default
				softreset_off:       softreset       <= wb_dat_w;
				startrender_off:     startrender     <= wb_dat_w;
				span_sort_cfg_off:   span_sort_cfg   <= wb_dat_w;
				vo_border_col_off:   vo_border_col   <= wb_dat_w;
				fb_r_ctrl_off:       fb_r_ctrl       <= wb_dat_w;
				fb_w_ctrl_off:       fb_w_ctrl       <= wb_dat_w;
				fb_w_linestride_off: fb_w_linestride <= wb_dat_w;
				fb_r_size_off:       fb_r_size       <= wb_dat_w;
				fb_w_sof1_off:       fb_w_sof1       <= wb_dat_w;
				fb_w_sof2_off:       fb_w_sof2       <= wb_dat_w;
				fb_x_clip_off:       fb_x_clip       <= wb_dat_w;
				fb_y_clip_off:       fb_y_clip       <= wb_dat_w;
				isp_backgnd_d_off:   isp_backgnd_d   <= wb_dat_w;
				isp_backgnd_t_off:   isp_backgnd_t   <= wb_dat_w;
				spg_control_off:     spg_control     <= wb_dat_w;
				vo_control_off:      vo_control      <= wb_dat_w;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (wb_adr)
			id_off:              reg_rdata = DEVICE_ID;
			revision_off:        reg_rdata = DEVICE_REVISION;
			softreset_off:       reg_rdata = softreset;
			startrender_off:     reg_rdata = startrender;
			param_base_off:      reg_rdata = param_base;
			region_base_off:     reg_rdata = region_base;
			span_sort_cfg_off:   reg_rdata = span_sort_cfg;
			vo_border_col_off:   reg_rdata = vo_border_col;
			fb_r_ctrl_off:       reg_rdata = fb_r_ctrl;
			fb_w_ctrl_off:       reg_rdata = fb_w_ctrl;
			fb_w_linestride_off: reg_rdata = fb_w_linestride;
			fb_r_sof1_off:       reg_rdata = fb_r_sof1;
			fb_r_sof2_off:       reg_rdata = fb_r_sof2;
			fb_r_size_off:       reg_rdata = fb_r_size;
			fb_w_sof1_off:       reg_rdata = fb_w_sof1;
			fb_w_sof2_off:       reg_rdata = fb_w_sof2;
			fb_x_clip_off:       reg_rdata = fb_x_clip;
			fb_y_clip_off:       reg_rdata = fb_y_clip;
			fpu_param_cfg_off:   reg_rdata = fpu_param_cfg;
			isp_backgnd_d_off:   reg_rdata = isp_backgnd_d;
			isp_backgnd_t_off:   reg_rdata = isp_backgnd_t;
			spg_control_off:     reg_rdata = spg_control;
			text_control_off:    reg_rdata = text_control;
			vo_control_off:      reg_rdata = vo_control;
			pal_ram_ctrl_off:    reg_rdata = pal_ram_ctrl;
			ta_alloc_ctrl_off:   reg_rdata = ta_alloc_ctrl;
			default:             reg_rdata = '0; // unmapped reads as zero
		endcase
	end

	// the bus side must only hand over whole word addresses
	wr_aligned: assert property (@(posedge clock) disable iff (!reset_n)
		reg_wr |-> (wb_adr[1:0] == 2'b00));

endmodule

// File: logic/pvr_regs.sv
`timescale 1ns/1ps

module pvr_regs
	import pvr_bus_pkg::*;
(
	input  logic      clock,
	input  logic      reset_n,
	input  logic      wb_cyc,          // wishbone classic slave
	input  logic      wb_stb,
	input  logic      wb_we,
	input  bus_addr_t wb_adr,
	input  bus_word_t wb_dat_w,
	output bus_word_t wb_dat_r,
	output logic      wb_ack,
	input  bus_word_t param_base,      // read back only
	input  bus_word_t region_base,
	input  bus_word_t fb_r_sof1,
	input  bus_word_t fb_r_sof2,
	input  bus_word_t fpu_param_cfg,
	input  bus_word_t text_control,
	input  bus_word_t pal_ram_ctrl,
	input  bus_word_t ta_alloc_ctrl,
	output bus_word_t softreset,       // control registers
	output bus_word_t startrender,
	output bus_word_t span_sort_cfg,
	output bus_word_t vo_border_col,
	output bus_word_t fb_r_ctrl,
	output bus_word_t fb_w_ctrl,
	output bus_word_t fb_w_linestride,
	output bus_word_t fb_r_size,
	output bus_word_t fb_w_sof1,
	output bus_word_t fb_w_sof2,
	output bus_word_t fb_x_clip,
	output bus_word_t fb_y_clip,
	output bus_word_t isp_backgnd_d,
	output bus_word_t isp_backgnd_t,
	output bus_word_t spg_control,
	output bus_word_t vo_control
);

	logic       reg_wr;    // fsm to reg file
	logic       pal_wr;    // fsm to palette
	logic       pal_rd;
	pal_index_t pal_index;
	bus_word_t  reg_rdata; // reg file mux output
	bus_word_t  pal_rdata; // registered ram output

	pvr_bus_fsm u_bus_fsm (.*);

	pvr_reg_file u_reg_file (.*);

	pvr_palette_ram u_palette_ram (
		.clock     (clock),
		.pal_wr    (pal_wr),
		.pal_rd    (pal_rd),
		.pal_index (pal_index),
		.wb_dat_w  (wb_dat_w),
		.pal_rdata (pal_rdata)
	);

endmodule

// File: testbench/pvr_regs_tb.sv
`timescale 1ns/1ps

module pvr_regs_tb
	import pvr_bus_pkg::*, pvr_map_pkg::*;
;

	localparam int N_XFERS = 18 + 32 + 14 + 128 + 4; // bus transfers over all tests
	localparam int LIMIT   = N_XFERS * 6 + 200;      // watchdog in clock cycles

	// the sixteen writable registers in output order
	localparam bus_addr_t ctrl_offs [16] = '{softreset_off, startrender_off, span_sort_cfg_off,
		vo_border_col_off, fb_r_ctrl_off, fb_w_ctrl_off, fb_w_linestride_off, fb_r_size_off,
		fb_w_sof1_off, fb_w_sof2_off, fb_x_clip_off, fb_y_clip_off, isp_backgnd_d_off,
		isp_backgnd_t_off, spg_control_off, vo_control_off};
	localparam bus_addr_t ext_offs [8] = '{param_base_off, region_base_off, fb_r_sof1_off,
		fb_r_sof2_off, fpu_param_cfg_off, text_control_off, pal_ram_ctrl_off, ta_alloc_ctrl_off};

	logic      clock, reset_n;
	logic      wb_cyc, wb_stb, wb_we, wb_ack;
	bus_addr_t wb_adr;
	bus_word_t wb_dat_w, wb_dat_r;
	bus_word_t param_base, region_base, fb_r_sof1, fb_r_sof2;
	bus_word_t fpu_param_cfg, text_control, pal_ram_ctrl, ta_alloc_ctrl;
	bus_word_t softreset, startrender, span_sort_cfg, vo_border_col, fb_r_ctrl, fb_w_ctrl;
	bus_word_t fb_w_linestride, fb_r_size, fb_w_sof1, fb_w_sof2, fb_x_clip, fb_y_clip;
	bus_word_t isp_backgnd_d, isp_backgnd_t, spg_control, vo_control;

	bus_word_t ext_vals [8];      // external words fed to the DUT
	bus_word_t ctrl_q [16];       // DUT control outputs in ctrl_offs order
	bus_word_t ctrl_model [16];   // expected control register contents
	bus_word_t pal_model [1024];  // expected palette contents
	pal_index_t pal_idx [64];
	int pass_count = 0;
	int fail_count = 0;
	int fails_before;             // fail count when the current test began
	int cycle_count = 0;
	bus_word_t rd_tmp;

	assign param_base    = ext_vals[0];
	assign region_base   = ext_vals[1];
	assign fb_r_sof1     = ext_vals[2];
	assign fb_r_sof2     = ext_vals[3];
	assign fpu_param_cfg = ext_vals[4];
	assign text_control  = ext_vals[5];
	assign pal_ram_ctrl  = ext_vals[6];
	assign ta_alloc_ctrl = ext_vals[7];

	assign ctrl_q[0]  = softreset;
	assign ctrl_q[1]  = startrender;
	assign ctrl_q[2]  = span_sort_cfg;
	assign ctrl_q[3]  = vo_border_col;
	assign ctrl_q[4]  = fb_r_ctrl;
	assign ctrl_q[5]  = fb_w_ctrl;
	assign ctrl_q[6]  = fb_w_linestride;
	assign ctrl_q[7]  = fb_r_size;
	assign ctrl_q[8]  = fb_w_sof1;
	assign ctrl_q[9]  = fb_w_sof2;
	assign ctrl_q[10] = fb_x_clip;
	assign ctrl_q[11] = fb_y_clip;
	assign ctrl_q[12] = isp_backgnd_d;
	assign ctrl_q[13] = isp_backgnd_t;
	assign ctrl_q[14] = spg_control;
	assign ctrl_q[15] = vo_control;

	pvr_regs uut (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock; // 40 ns period
	end

	// bus protocol seen from the master side
	ack_needs_stb: assert property (@(posedge clock) disable iff (!reset_n)
		wb_ack |-> (wb_cyc && wb_stb)) else begin
		fail_count++;
		$display("ack was raised while no request was active");
	end

	ack_single: assert property (@(posedge clock) disable iff (!reset_n)
		wb_ack |=> !wb_ack) else begin
		fail_count++;
		$display("ack stayed high for more than one cycle");
	end

	task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
		assert (act === exp) pass_count++;
		else begin
			fail_count++;
			$display("[FAIL] %s expected %08h actual %08h", name, exp, act);
		end
	endtask

	// one transfer from 2 ns after an edge to 2 ns after a later edge
	task automatic bus_xfer(input logic we, input bus_addr_t adr, input bus_word_t wdata,
		input string name, output bus_word_t rdata);
		int waits;
		int gap;
		int exp_lat;
		exp_lat = (adr[15:12] == 4'h1 && !we) ? 2 : 1; // palette read needs the ram cycle
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		waits    = 0;
		do begin
			@(negedge clock); // ack and read data are settled mid cycle
			waits++;
		end while (!wb_ack);
		rdata = wb_dat_r;
		check_word({name, "_latency"}, exp_lat, waits - 1); // first negedge precedes acceptance
		@(posedge clock);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		gap = $urandom_range(2, 0);
		repeat (gap + 1) begin // stb low for at least one cycle
			@(posedge clock);
			#2;
		end
	endtask

	task automatic write_word(input bus_addr_t adr, input bus_word_t data, input string name);
		bus_word_t unused_rd;
		bus_xfer(1'b1, adr, data, name, unused_rd);
	endtask

	task automatic read_check(input bus_addr_t adr, input bus_word_t exp, input string name);
		bus_word_t got;
		bus_xfer(1'b0, adr, '0, name, got);
		check_word(name, exp, got);
	endtask

	task automatic report_test(input string name);
		$display("test %-12s %s (%0d failed checks)", name,
			(fail_count == fails_before) ? "done" : "FAILED", fail_count - fails_before);
		fails_before = fail_count;
	endtask

	// watchdog on the cycle count
	initial begin
		while (cycle_count < LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("run stopped after %0d cycles without finishing the tests", LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(64175));
		reset_n  = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		fails_before = 0;
		for (int i = 0; i < 8; i++)
			ext_vals[i] = '0;
		for (int i = 0; i < 16; i++)
			ctrl_model[i] = '0;
		repeat (4) @(posedge clock);
		#2;
		reset_n = 1'b1;

		// reset state
		repeat (3) begin
			@(negedge clock);
			check_word("idle_ack", 32'h0, 32'(wb_ack)); // ack stays low without stb
		end
		@(posedge clock);
		#2;
		read_check(id_off, 32'h17FD11DB, "reset_id");
		read_check(revision_off, 32'h00000011, "reset_rev");
		for (int i = 0; i < 16; i++) begin
			read_check(ctrl_offs[i], 32'h0, $sformatf("reset_reg%0d", i));
			check_word($sformatf("reset_out%0d", i), 32'h0, ctrl_q[i]);
		end
		report_test("reset");

		// control registers
		for (int i = 0; i < 16; i++) begin
			ctrl_model[i] = $urandom;
			write_word(ctrl_offs[i], ctrl_model[i], $sformatf("ctrl_wr%0d", i));
		end
		for (int i = 0; i < 16; i++) begin
			read_check(ctrl_offs[i], ctrl_model[i], $sformatf("ctrl_rd%0d", i));
			check_word($sformatf("ctrl_out%0d", i), ctrl_model[i], ctrl_q[i]);
		end
		report_test("control");

		// external words and ignored writes
		for (int i = 0; i < 8; i++)
			ext_vals[i] = $urandom;
		for (int i = 0; i < 8; i++)
			read_check(ext_offs[i], ext_vals[i], $sformatf("ext_rd%0d", i));
		write_word(id_off, $urandom, "id_wr");
		write_word(ext_offs[2], $urandom, "ext_wr");
		write_word(16'h0100, $urandom, "unmapped_wr");
		read_check(id_off, 32'h17FD11DB, "id_kept");
		read_check(ext_offs[2], ext_vals[2], "ext_kept");
		read_check(16'h0100, 32'h0, "unmapped_rd");
		for (int i = 0; i < 16; i++)
			check_word($sformatf("ignored_out%0d", i), ctrl_model[i], ctrl_q[i]);
		report_test("ignored");

		// palette where a repeated index keeps the last value
		for (int k = 0; k < 64; k++) begin
			if (k == 63)
				pal_idx[k] = pal_idx[0]; // overwrite of the first index
			else
				pal_idx[k] = pal_index_t'($urandom_range(1023, 0));
			rd_tmp = $urandom;
			pal_model[pal_idx[k]] = rd_tmp;
			write_word({4'h1, pal_idx[k], 2'b00}, rd_tmp, $sformatf("pal_wr%0d", k));
		end
		for (int k = 0; k < 64; k++)
			read_check({4'h1, pal_idx[k], 2'b00}, pal_model[pal_idx[k]],
				$sformatf("pal_rd%0d", k));
		for (int i = 0; i < 16; i++)
			check_word($sformatf("pal_out%0d", i), ctrl_model[i], ctrl_q[i]);
		report_test("palette");

		// latency of each access kind including the top palette word
		ctrl_model[10] = $urandom;
		write_word(fb_x_clip_off, ctrl_model[10], "hs_reg_wr");
		pal_model[1023] = $urandom;
		write_word(16'h1FFC, pal_model[1023], "hs_pal_wr");
		read_check(16'h1FFC, pal_model[1023], "hs_pal_rd");
		read_check(fb_x_clip_off, ctrl_model[10], "hs_reg_rd");
		report_test("handshake");

		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
